//--- tb/mips_stim.txt
// Columns: kind, address, data (hex)
// Kind 1 loads a memory word, 2 is an expected store, 3 is the expected final register_v0
1 BFC00000 24090005
1 BFC00004 3C08BFC0
1 BFC00008 00095100
1 BFC0000C 01495023
1 BFC00010 AD0A0100
1 BFC00014 8D020100
1 BFC00018 10490001
1 BFC0001C 14490001
1 BFC00020 3402DEAD
1 BFC00024 0FF0000D
1 BFC00028 0BF0000C
1 BFC0002C 3402BEEF
1 BFC00030 00000008
1 BFC00034 00085D03
1 BFC00038 0160602A
1 BFC0003C 000B682B
1 BFC00040 158D0002
1 BFC00044 004C1021
1 BFC00048 118D0001
1 BFC0004C 3402F00D
1 BFC00050 38420300
1 BFC00054 AD020104
1 BFC00058 03E00008
2 BFC00100 0000004B
2 BFC00104 0000034C
3 00000000 0000034C

//--- tb.f
+incdir+common
common/mips_pkg.sv
rtl/decode.sv
rtl/regfile.sv
rtl/alu.sv
rtl/pc_control.sv
load_store/load_store.sv
rtl/mips_cpu_bus.sv
tb/mips_cpu_bus_tb.sv

//--- tb/mips_cpu_bus_tb.sv
`default_nettype none

`include "mips_cfg.svh"

module mips_cpu_bus_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 256;    // 1 KB window at the reset vector
    localparam int STIM_RECS = 26;     // Records in the stim file
    localparam int TIMEOUT   = 2000;   // Cycles per wait

    logic            clk;
    logic            rst_n;
    logic            active;
    logic            waitrequest;
    logic            read;
    logic            write;
    logic [3:0]      byteenable;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t readdata;
    mips_pkg::word_t address;
    mips_pkg::word_t writedata;

    mips_pkg::word_t mem [MEM_WORDS];
    mips_pkg::word_t stim [3 * STIM_RECS];  // kind, address, data per record
    mips_pkg::word_t exp_addr [$];          // Stores in program order
    mips_pkg::word_t exp_data [$];
    mips_pkg::word_t exp_v0;
    logic [31:0]     lfsr = 32'hab3f_8226;
    int              errors = 0;
    int              checks = 0;
    int              wait_left = 0;         // Stall cycles left on this request
    logic            pending = 1'b0;
    logic            first_read_seen = 1'b0;
    logic            rst_at_edge;

    mips_cpu_bus mips_cpu_bus_inst (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .waitrequest(waitrequest), .readdata(readdata), .address(address),
        .write(write), .read(read), .writedata(writedata), .byteenable(byteenable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_wait_count(output int count);
        count = 0;
        lfsr = lfsr_next(lfsr);
        count[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        count[1] = lfsr[0];  // 0 to 3 stall cycles
    endtask

    function automatic int unsigned mem_index(input logic [31:0] addr);
        return (addr - `MIPS_RESET_VECTOR) >> 2;  // Below the window wraps out of range
    endfunction

    task automatic load_stim();
        int i;
        mips_pkg::word_t kind;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~(`MIPS_RESET_VECTOR + (i << 2));  // Fill tied to full address
        end
        $readmemh("tb/mips_stim.txt", stim);
        for (i = 0; i < STIM_RECS; i++) begin
            kind = stim[3 * i];
            case (kind)
                32'd1: mem[mem_index(stim[3 * i + 1])] = stim[3 * i + 2];
                32'd2: begin
                    exp_addr.push_back(stim[3 * i + 1]);
                    exp_data.push_back(stim[3 * i + 2]);
                end
                32'd3: exp_v0 = stim[3 * i + 2];
                default: begin
                    $display("Stim record %0d has an unknown kind %h", i, kind);
                    errors++;
                end
            endcase
        end
    endtask

    // Completes the request held on the bus at the next edge
    task automatic serve_access();
        int unsigned idx;
        idx = mem_index(address);
        if (idx >= MEM_WORDS) begin
            $display("Bus access at address %h falls outside the memory model", address);
            errors++;
        end else if (read) begin
            readdata = mem[idx];
        end else begin
            check_equal("store byteenable", 32'hf, {28'd0, byteenable});
            if (exp_addr.size() == 0) begin
                $display("Store of %h to %h was not expected", writedata, address);
                errors++;
            end else begin
                check_equal("store address", exp_addr.pop_front(), address);
                check_equal("store data", exp_data.pop_front(), writedata);
            end
            mem[idx] = writedata;  // Read back by later loads
        end
    endtask

    // Memory model and bus monitor
    always @(posedge clk) begin
        rst_at_edge = rst_n;
        #2;
        if (!rst_at_edge) begin  // Reset cycles and the first one after
            check_equal("read during reset", 32'd0, {31'd0, read});
            check_equal("write during reset", 32'd0, {31'd0, write});
        end
        if (read && !first_read_seen) begin
            first_read_seen = 1'b1;
            check_equal("first fetch address", `MIPS_RESET_VECTOR, address);
        end
        if (read || write) begin
            if (!pending) begin  // New request
                draw_wait_count(wait_left);
                pending = 1'b1;
            end
            if (wait_left > 0) begin
                waitrequest = 1'b1;
                wait_left--;
            end else begin
                waitrequest = 1'b0;
                pending = 1'b0;
                serve_access();
            end
        end else begin
            waitrequest = 1'b1;
        end
    end

    task automatic wait_for_active(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (active !== level && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (active !== level) begin
            $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
            errors++;
            finish_run();
        end
    endtask

    initial begin
        rst_n = 1'b0;
        waitrequest = 1'b1;
        readdata = '0;
        load_stim();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait_for_active(1'b1, "active to rise after reset");
        wait_for_active(1'b0, "the core to halt");
        repeat (50) begin  // Halted core stays off the bus
            @(posedge clk);
            #3;
            check_equal("bus idle after halt", 32'd0, {30'd0, read, write});
        end
        check_equal("final register_v0", exp_v0, register_v0);
        if (exp_addr.size() != 0) begin
            $display("%0d expected stores never appeared on the bus", exp_addr.size());
            errors++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- rtl/mips_cpu_bus.sv
`default_nettype none

module mips_cpu_bus (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,

    input  logic            waitrequest,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable
);

    mips_pkg::cpu_state_t state;
    mips_pkg::word_t      pc;
    mips_pkg::word_t      instr;    // From the instruction register
    mips_pkg::decoded_t   dec;
    mips_pkg::word_t      rs_data;
    mips_pkg::word_t      rt_data;
    mips_pkg::wb_t        alu_wb;
    mips_pkg::wb_t        ld_wb;
    mips_pkg::wb_t        link_wb;  // jal return address
    logic                 bus_done;

    decode decode_inst (.instr(instr), .dec(dec));

    regfile regfile_inst (
        .clk(clk), .rst_n(rst_n), .dec(dec),
        .alu_wb(alu_wb), .ld_wb(ld_wb), .link_wb(link_wb),
        .rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
    );

    pc_control pc_control_inst (
        .clk(clk), .rst_n(rst_n), .dec(dec),
        .rs_data(rs_data), .rt_data(rt_data), .bus_done(bus_done),
        .state(state), .pc(pc), .link_wb(link_wb), .active(active)
    );

    alu alu_inst (
        .state(state), .dec(dec),
        .rs_data(rs_data), .rt_data(rt_data), .alu_wb(alu_wb)
    );

    // Sole bus master
    load_store load_store_inst (
        .clk(clk), .rst_n(rst_n), .state(state), .pc(pc), .dec(dec),
        .rs_data(rs_data), .rt_data(rt_data),
        .readdata(readdata), .waitrequest(waitrequest),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable),
        .instr(instr), .bus_done(bus_done), .ld_wb(ld_wb)
    );

endmodule

`default_nettype wire

//--- load_store/load_store.sv
`default_nettype none

module load_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::decoded_t   dec,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    input  mips_pkg::word_t      readdata,
    input  logic                 waitrequest,
    output mips_pkg::word_t      address,
    output logic                 read,
    output logic                 write,
    output mips_pkg::word_t      writedata,
    output logic [3:0]           byteenable,
    output mips_pkg::word_t      instr,
    output logic                 bus_done,
    output mips_pkg::wb_t        ld_wb
);

    mips_pkg::word_t data_addr;
    logic            fetch_req;
    logic            load_req;
    logic            store_req;
    logic            rd_q;       // Read request on the bus
    logic            wr_q;       // Write request on the bus

    assign data_addr = rs_data + {{16{dec.imm[15]}}, dec.imm};  // base + offset

    // Address zero is the halt address and is never fetched
    assign fetch_req = (state == mips_pkg::FETCH) && (pc != '0);
    assign load_req  = (state == mips_pkg::MEM) && (dec.op == mips_pkg::OP_LW);
    assign store_req = (state == mips_pkg::MEM) && (dec.op == mips_pkg::OP_SW);

    // Request held until an edge with waitrequest low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (bus_done) begin
            rd_q <= 1'b0;
            wr_q <= 1'b0;
        end else if (!rd_q && !wr_q) begin  // Idle, start the next access
            rd_q <= fetch_req || load_req;
            wr_q <= store_req;
        end
    end

    assign read       = rd_q;
    assign write      = wr_q;
    assign bus_done   = (rd_q || wr_q) && !waitrequest;
    assign address    = (state == mips_pkg::MEM) ? data_addr : pc;  // Steady in MEM
    assign writedata  = rt_data;
    assign byteenable = 4'b1111;  // Word accesses only

    // Instruction register
    always_ff @(posedge clk) begin
        if (state == mips_pkg::FETCH && bus_done) begin
            instr <= readdata;
        end
    end

    // lw result goes to rt on the completing edge
    always_comb begin
        ld_wb.en   = load_req && bus_done;
        ld_wb.addr = dec.rt;
        ld_wb.data = readdata;
    end

endmodule

`default_nettype wire

//--- rtl/pc_control.sv
`default_nettype none

`include "mips_cfg.svh"

module pc_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::decoded_t   dec,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    input  logic                 bus_done,
    output mips_pkg::cpu_state_t state,
    output mips_pkg::word_t      pc,
    output mips_pkg::wb_t        link_wb,
    output logic                 active
);

    mips_pkg::cpu_state_t state_d;
    mips_pkg::word_t      pc_d;
    mips_pkg::word_t      pc_plus4;
    mips_pkg::word_t      br_target;
    mips_pkg::word_t      j_target;

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {{14{dec.imm[15]}}, dec.imm, 2'b00};
    assign j_target  = {pc_plus4[31:28], dec.target, 2'b00};  // Same 256 MB region

    always_comb begin
        state_d = state;
        pc_d    = pc;  // PC only moves in EXEC
        case (state)
            mips_pkg::FETCH: if (bus_done) state_d = mips_pkg::EXEC;
            mips_pkg::EXEC: begin
                state_d = mips_pkg::FETCH;
                pc_d    = pc_plus4;  // No delay slot
                case (dec.op)
                    mips_pkg::OP_BEQ: if (rs_data == rt_data) pc_d = br_target;
                    mips_pkg::OP_BNE: if (rs_data != rt_data) pc_d = br_target;
                    mips_pkg::OP_J, mips_pkg::OP_JAL: pc_d = j_target;
                    mips_pkg::OP_JR: pc_d = rs_data;
                    mips_pkg::OP_LW, mips_pkg::OP_SW: state_d = mips_pkg::MEM;
                    default: ;
                endcase
            end
            mips_pkg::MEM: if (bus_done) state_d = mips_pkg::FETCH;
            default: state_d = mips_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= mips_pkg::FETCH;
            pc     <= `MIPS_RESET_VECTOR;
            active <= 1'b0;
        end else begin
            state  <= state_d;
            pc     <= pc_d;
            active <= (pc_d != '0);  // Jump to zero halts, pc parks at 0
        end
    end

    // Return address for jal
    always_comb begin
        link_wb.en   = (state == mips_pkg::EXEC) && (dec.op == mips_pkg::OP_JAL);
        link_wb.addr = `MIPS_LINK_REG;
        link_wb.data = pc_plus4;
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu (
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::decoded_t   dec,
    input  mips_pkg::word_t      rs_data,
    input  mips_pkg::word_t      rt_data,
    output mips_pkg::wb_t        alu_wb
);

    mips_pkg::word_t imm_sext;
    mips_pkg::word_t imm_zext;
    mips_pkg::word_t result;
    logic            is_alu;   // Op writes through the ALU
    logic            r_type;   // Destination is rd, else rt

    assign imm_sext = {{16{dec.imm[15]}}, dec.imm};
    assign imm_zext = {16'h0000, dec.imm};  // Logical immediates

    always_comb begin
        result = '0;
        is_alu = 1'b1;
        r_type = 1'b1;
        case (dec.op)
            mips_pkg::OP_ADDU: result = rs_data + rt_data;
            mips_pkg::OP_SUBU: result = rs_data - rt_data;
            mips_pkg::OP_AND:  result = rs_data & rt_data;
            mips_pkg::OP_OR:   result = rs_data | rt_data;
            mips_pkg::OP_XOR:  result = rs_data ^ rt_data;
            mips_pkg::OP_SLT:  result = {31'd0, $signed(rs_data) < $signed(rt_data)};
            mips_pkg::OP_SLTU: result = {31'd0, rs_data < rt_data};
            mips_pkg::OP_SLL:  result = rt_data << dec.shamt;
            mips_pkg::OP_SRL:  result = rt_data >> dec.shamt;
            mips_pkg::OP_SRA:  result = $signed(rt_data) >>> dec.shamt;  // Keeps sign
            mips_pkg::OP_ADDIU: begin
                result = rs_data + imm_sext;  // No overflow trap
                r_type = 1'b0;
            end
            mips_pkg::OP_ANDI: begin
                result = rs_data & imm_zext;
                r_type = 1'b0;
            end
            mips_pkg::OP_ORI: begin
                result = rs_data | imm_zext;
                r_type = 1'b0;
            end
            mips_pkg::OP_XORI: begin
                result = rs_data ^ imm_zext;
                r_type = 1'b0;
            end
            mips_pkg::OP_LUI: begin
                result = {dec.imm, 16'h0000};
                r_type = 1'b0;
            end
            default: begin  // Memory, control flow, illegal
                is_alu = 1'b0;
                r_type = 1'b0;
            end
        endcase
    end

    always_comb begin
        alu_wb.en   = (state == mips_pkg::EXEC) && is_alu;  // Written at end of EXEC
        alu_wb.addr = r_type ? dec.rd : dec.rt;
        alu_wb.data = result;
    end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`default_nettype none

`include "mips_cfg.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  mips_pkg::decoded_t dec,
    input  mips_pkg::wb_t      alu_wb,
    input  mips_pkg::wb_t      ld_wb,
    input  mips_pkg::wb_t      link_wb,
    output mips_pkg::word_t    rs_data,
    output mips_pkg::word_t    rt_data,
    output mips_pkg::word_t    register_v0
);

    mips_pkg::word_t regs [32];
    mips_pkg::wb_t   wb;  // The one enabled source

    // Sources never overlap, order is arbitrary
    assign wb = alu_wb.en ? alu_wb : (ld_wb.en ? ld_wb : link_wb);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != 5'd0) begin  // $zero stays 0
            regs[wb.addr] <= wb.data;
        end
    end

    assign rs_data     = regs[dec.rs];
    assign rt_data     = regs[dec.rt];
    assign register_v0 = regs[`MIPS_V0_REG];

endmodule

`default_nettype wire

//--- rtl/decode.sv
`default_nettype none

module decode (
    input  mips_pkg::word_t    instr,
    output mips_pkg::decoded_t dec
);

    logic [5:0]    opcode;
    logic [5:0]    funct;
    mips_pkg::op_t op;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        op = mips_pkg::OP_ILLEGAL;  // Anything unmatched
        case (opcode)
            6'h00: begin  // SPECIAL, picked by funct
                case (funct)
                    6'h00: op = mips_pkg::OP_SLL;
                    6'h02: op = mips_pkg::OP_SRL;
                    6'h03: op = mips_pkg::OP_SRA;
                    6'h08: begin
                        // jr needs rt clear
                        if (instr[20:16] == 5'd0) begin
                            op = mips_pkg::OP_JR;
                        end
                    end
                    6'h21: op = mips_pkg::OP_ADDU;
                    6'h23: op = mips_pkg::OP_SUBU;
                    6'h24: op = mips_pkg::OP_AND;
                    6'h25: op = mips_pkg::OP_OR;
                    6'h26: op = mips_pkg::OP_XOR;
                    6'h2a: op = mips_pkg::OP_SLT;
                    6'h2b: op = mips_pkg::OP_SLTU;
                    default: op = mips_pkg::OP_ILLEGAL;
                endcase
            end
            6'h02: op = mips_pkg::OP_J;
            6'h03: op = mips_pkg::OP_JAL;
            6'h04: op = mips_pkg::OP_BEQ;
            6'h05: op = mips_pkg::OP_BNE;
            6'h09: op = mips_pkg::OP_ADDIU;
            6'h0c: op = mips_pkg::OP_ANDI;
            6'h0d: op = mips_pkg::OP_ORI;
            6'h0e: op = mips_pkg::OP_XORI;
            6'h0f: op = mips_pkg::OP_LUI;
            6'h23: op = mips_pkg::OP_LW;
            6'h2b: op = mips_pkg::OP_SW;
            default: op = mips_pkg::OP_ILLEGAL;  // REGIMM, HI/LO, byte ops
        endcase
    end

    // Fixed field positions
    assign dec.op     = op;
    assign dec.rs     = instr[25:21];
    assign dec.rt     = instr[20:16];
    assign dec.rd     = instr[15:11];
    assign dec.shamt  = instr[10:6];
    assign dec.imm    = instr[15:0];
    assign dec.target = instr[25:0];

endmodule

`default_nettype wire

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  reg_addr_t;  // Register number
    typedef logic [4:0]  shamt_t;     // Shift amount
    typedef logic [15:0] imm_t;       // I-type immediate
    typedef logic [25:0] jtarget_t;   // J-type word target

    // Supported operations
    typedef enum logic [4:0] {
        OP_ILLEGAL,  // Runs as a no-op
        OP_ADDIU, OP_ADDU, OP_SUBU,
        OP_AND, OP_OR, OP_XOR,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LW, OP_SW,
        OP_BEQ, OP_BNE, OP_J, OP_JAL, OP_JR
    } op_t;

    // Sequencer states
    typedef enum logic [1:0] {
        FETCH,  // Instruction read on the bus
        EXEC,   // One cycle, ALU and PC update
        MEM     // Data access for lw and sw
    } cpu_state_t;

    typedef struct packed {
        op_t       op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        shamt_t    shamt;
        imm_t      imm;
        jtarget_t  target;
    } decoded_t;

    // One register write request
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

//--- common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Boot ROM address of the first fetch
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// Register mirrored on register_v0
// Holds $v0, the return value register
`define MIPS_V0_REG 5'd2

// Register written by jal
`define MIPS_LINK_REG 5'd31

`endif
